/* hdl/fprint_pkg.sv */
package fprint_pkg;

	// bus widths
	localparam int addr_width = 8;
	localparam int data_width = 32;

	// physical core id sits in the upper address bits, register offset below it
	localparam int num_phys_cores = 16;
	localparam int phys_width = $clog2(num_phys_cores);
	localparam int offset_width = addr_width - phys_width;

	// task ids
	localparam int task_width = 4;
	localparam int num_tasks = 2 ** task_width;

	// fingerprints arrive as two halves in the top bits of writedata
	localparam int crc_width = 32;
	localparam int half_width = crc_width / 2;

	// register offsets
	localparam logic [offset_width-1:0] cs_offset = 0;
	localparam logic [offset_width-1:0] crc_offset = 1;
	localparam logic [offset_width-1:0] map_offset = 2;

	// set for check-out, clear for check-in
	localparam int checkout_bit = 4;
	// 0 selects the low half, 1 the high half
	localparam int block_bit = 5;

endpackage

/* hdl/core_map_csr.sv */
`timescale 1ns/100ps

module core_map_csr (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [fprint_pkg::phys_width-1:0]  phys_core,
	input  logic                               map_write,
	input  logic                               map_value,
	output logic                               logical_core
);
	import fprint_pkg::*;

	// one bit per physical core, selects which redundant copy it runs
	logic [num_phys_cores-1:0] core_map;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			core_map <= '0;
		end else if (map_write) begin
			core_map[phys_core] <= map_value;
		end
	end

	// plain lookup, the register block needs the answer in the same cycle
	assign logical_core = core_map[phys_core];

endmodule

/* hdl/fprint_registers.sv */
`timescale 1ns/100ps

module fprint_registers #(
	parameter int ram_addr_width = 4
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [fprint_pkg::addr_width-1:0]   address,
	input  logic                                write,
	input  logic [fprint_pkg::data_width-1:0]   writedata,
	input  logic                                logical_core,
	input  logic [ram_addr_width-1:0]           head_ptr,
	input  logic                                incr_ack,
	input  logic                                verify_req,
	input  logic [fprint_pkg::task_width-1:0]   verify_task,
	input  logic [ram_addr_width-1:0]           tail_ptr,
	output logic                                waitrequest,
	output logic [fprint_pkg::phys_width-1:0]   phys_core,
	output logic                                map_write,
	output logic                                map_value,
	output logic                                incr_req,
	output logic                                incr_core,
	output logic                                verify_ack,
	output logic [fprint_pkg::num_tasks-1:0]    checkin_both,
	output logic [fprint_pkg::crc_width-1:0]    fprint0,
	output logic [fprint_pkg::crc_width-1:0]    fprint1,
	output logic [fprint_pkg::task_width-1:0]   task0,
	output logic [fprint_pkg::task_width-1:0]   task1
);
	import fprint_pkg::*;

	localparam int ram_depth = 2 ** ram_addr_width;

	typedef enum logic [2:0] {
		st_idle,
		st_reg_store,
		st_crc_store_0,
		st_crc_store_1,
		st_incr_wait,
		st_waitrequest,
		st_verify
	} state_t;

	state_t state;

	logic [offset_width-1:0] offset;
	logic [task_width-1:0]   wr_task;
	logic [half_width-1:0]   wr_half;
	logic                    cs_sel;
	logic                    crc_sel;
	logic                    map_sel;
	logic                    block;
	logic                    checked_out;
	logic                    store_half;

	// per logical core task bits
	logic [num_tasks-1:0] checkout_reg [2];
	logic [num_tasks-1:0] checkin_reg [2];

	// fingerprint rings, one memory per core and half, plus the task id
	logic [half_width-1:0] lo_mem0 [ram_depth];
	logic [half_width-1:0] hi_mem0 [ram_depth];
	logic [half_width-1:0] lo_mem1 [ram_depth];
	logic [half_width-1:0] hi_mem1 [ram_depth];
	logic [task_width-1:0] task_mem0 [ram_depth];
	logic [task_width-1:0] task_mem1 [ram_depth];

	// address and data decode
	assign phys_core = address[addr_width-1 -: phys_width];
	assign offset    = address[offset_width-1:0];
	assign wr_task   = writedata[task_width-1:0];
	assign wr_half   = writedata[data_width-1 -: half_width];
	assign block     = writedata[block_bit];
	assign cs_sel    = (offset == cs_offset);
	assign crc_sel   = (offset == crc_offset);
	assign map_sel   = (offset == map_offset);

	assign checked_out = checkout_reg[logical_core][wr_task];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					// bus writes win over a waiting verify request
					if (write) begin
						state <= crc_sel ? st_crc_store_0 : st_reg_store;
					end else if (verify_req && !verify_ack) begin
						state <= st_verify;
					end
				end
				st_reg_store:   state <= st_waitrequest;
				st_crc_store_0: state <= checked_out ? st_crc_store_1 : st_waitrequest;
				st_crc_store_1: state <= block ? st_incr_wait : st_waitrequest;
				st_incr_wait: begin
					if (incr_ack)
						state <= st_waitrequest;
				end
				st_waitrequest: state <= st_idle;
				st_verify: begin
					if (verify_ack && !verify_req)
						state <= st_idle;
				end
				default:        state <= st_idle;
			endcase
		end
	end

	assign waitrequest = (state != st_waitrequest);
	assign map_write   = (state == st_reg_store) && map_sel;
	assign map_value   = writedata[0];
	assign incr_req    = (state == st_incr_wait);
	assign incr_core   = logical_core;
	assign store_half  = (state == st_crc_store_1);

	assign checkin_both = checkin_reg[0] & checkin_reg[1];

	// check-out/check-in bits and the verify side of the handshake
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			checkout_reg[0] <= '0;
			checkout_reg[1] <= '0;
			checkin_reg[0]  <= '0;
			checkin_reg[1]  <= '0;
			verify_ack      <= 1'b0;
		end else if (state == st_verify) begin
			if (!verify_ack) begin
				checkout_reg[0][verify_task] <= 1'b0;
				checkout_reg[1][verify_task] <= 1'b0;
				checkin_reg[0][verify_task]  <= 1'b0;
				checkin_reg[1][verify_task]  <= 1'b0;
				verify_ack                   <= 1'b1;
			end else if (!verify_req) begin
				verify_ack <= 1'b0;
			end
		end else if (state == st_reg_store && cs_sel) begin
			if (writedata[checkout_bit])
				checkout_reg[logical_core][wr_task] <= 1'b1;
			// a check-in without a prior check-out is dropped
			else if (checked_out)
				checkin_reg[logical_core][wr_task] <= 1'b1;
		end
	end

	// ring writes land at the head of the logical core being written
	always_ff @(posedge clk) begin
		if (store_half && !logical_core) begin
			task_mem0[head_ptr] <= wr_task;
			if (block)
				hi_mem0[head_ptr] <= wr_half;
			else
				lo_mem0[head_ptr] <= wr_half;
		end
		if (store_half && logical_core) begin
			task_mem1[head_ptr] <= wr_task;
			if (block)
				hi_mem1[head_ptr] <= wr_half;
			else
				lo_mem1[head_ptr] <= wr_half;
		end
	end

	// registered read at the shared tail
	always_ff @(posedge clk) begin
		fprint0 <= {hi_mem0[tail_ptr], lo_mem0[tail_ptr]};
		fprint1 <= {hi_mem1[tail_ptr], lo_mem1[tail_ptr]};
		task0   <= task_mem0[tail_ptr];
		task1   <= task_mem1[tail_ptr];
	end

endmodule

/* hdl/fprint_pointers.sv */
`timescale 1ns/100ps

module fprint_pointers #(
	parameter int ram_addr_width = 4
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      incr_req,
	input  logic                      incr_core,
	input  logic                      tail_advance,
	output logic                      incr_ack,
	output logic [ram_addr_width-1:0] head_ptr,
	output logic [ram_addr_width-1:0] head0,
	output logic [ram_addr_width-1:0] head1,
	output logic [ram_addr_width-1:0] tail_ptr
);

	// heads advance once per request, then ack is held until req goes away
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			head0    <= '0;
			head1    <= '0;
			incr_ack <= 1'b0;
		end else if (incr_req && !incr_ack) begin
			if (incr_core)
				head1 <= head1 + 1'b1;
			else
				head0 <= head0 + 1'b1;
			incr_ack <= 1'b1;
		end else if (!incr_req) begin
			incr_ack <= 1'b0;
		end
	end

	// one tail serves both rings since entries are compared pairwise
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tail_ptr <= '0;
		end else if (tail_advance) begin
			tail_ptr <= tail_ptr + 1'b1;
		end
	end

	// write address for the core currently storing
	assign head_ptr = incr_core ? head1 : head0;

endmodule

/* hdl/fprint_comparator.sv */
`timescale 1ns/100ps

module fprint_comparator #(
	parameter int ram_addr_width = 4
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [ram_addr_width-1:0]         head0,
	input  logic [ram_addr_width-1:0]         head1,
	input  logic [ram_addr_width-1:0]         tail_ptr,
	input  logic [fprint_pkg::crc_width-1:0]  fprint0,
	input  logic [fprint_pkg::crc_width-1:0]  fprint1,
	input  logic [fprint_pkg::task_width-1:0] task0,
	input  logic [fprint_pkg::task_width-1:0] task1,
	input  logic [fprint_pkg::num_tasks-1:0]  checkin_both,
	input  logic                              verify_ack,
	output logic                              tail_advance,
	output logic                              mismatch,
	output logic [fprint_pkg::task_width-1:0] mismatch_task,
	output logic                              verify_req,
	output logic [fprint_pkg::task_width-1:0] verify_task,
	output logic                              verified,
	output logic [fprint_pkg::task_width-1:0] verified_task
);
	import fprint_pkg::*;

	logic settled;
	logic compare_now;
	logic differ;
	logic rings_empty;
	logic verify_ack_q;

	function automatic logic [task_width-1:0] lowest_task(input logic [num_tasks-1:0] mask);
		logic [task_width-1:0] idx;
		idx = '0;
		for (int i = num_tasks - 1; i >= 0; i--) begin
			if (mask[i])
				idx = task_width'(i);
		end
		return idx;
	endfunction

	// read data lags the tail by a cycle, hold off right after each move
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			settled <= 1'b0;
		else
			settled <= !tail_advance;
	end

	assign compare_now  = settled && (head0 != tail_ptr) && (head1 != tail_ptr);
	assign differ       = (fprint0 != fprint1) || (task0 != task1);
	assign rings_empty  = (head0 == tail_ptr) && (head1 == tail_ptr);
	assign tail_advance = compare_now;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			mismatch <= 1'b0;
		else
			mismatch <= compare_now && differ;
	end

	always_ff @(posedge clk) begin
		if (compare_now)
			mismatch_task <= task0;
	end

	// request side of the verify handshake
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			verify_req <= 1'b0;
		end else if (verify_req) begin
			if (verify_ack)
				verify_req <= 1'b0;
		end else if (!verify_ack && rings_empty && (|checkin_both)) begin
			verify_req <= 1'b1;
		end
	end

	// task is latched with the request and held through the handshake
	always_ff @(posedge clk) begin
		if (!verify_req && !verify_ack)
			verify_task <= lowest_task(checkin_both);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			verify_ack_q <= 1'b0;
		else
			verify_ack_q <= verify_ack;
	end

	// pulse on the rising edge of the ack
	assign verified      = verify_ack && !verify_ack_q;
	assign verified_task = verify_task;

endmodule

/* hdl/fprint_unit.sv */
`timescale 1ns/100ps

module fprint_unit #(
	parameter int ram_addr_width = 4
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [fprint_pkg::addr_width-1:0] address,
	input  logic                              write,
	input  logic [fprint_pkg::data_width-1:0] writedata,
	output logic                              waitrequest,
	output logic                              mismatch,
	output logic [fprint_pkg::task_width-1:0] mismatch_task,
	output logic                              verified,
	output logic [fprint_pkg::task_width-1:0] verified_task
);
	import fprint_pkg::*;

	logic [phys_width-1:0]     phys_core;
	logic                      logical_core;
	logic                      map_write;
	logic                      map_value;
	logic                      incr_req;
	logic                      incr_core;
	logic                      incr_ack;
	logic [ram_addr_width-1:0] head_ptr;
	logic [ram_addr_width-1:0] head0;
	logic [ram_addr_width-1:0] head1;
	logic [ram_addr_width-1:0] tail_ptr;
	logic                      tail_advance;
	logic                      verify_req;
	logic [task_width-1:0]     verify_task;
	logic                      verify_ack;
	logic [num_tasks-1:0]      checkin_both;
	logic [crc_width-1:0]      fprint0;
	logic [crc_width-1:0]      fprint1;
	logic [task_width-1:0]     task0;
	logic [task_width-1:0]     task1;

	core_map_csr map0 (
		.clk          (clk),
		.reset        (reset),
		.phys_core    (phys_core),
		.map_write    (map_write),
		.map_value    (map_value),
		.logical_core (logical_core)
	);

	fprint_registers #(
		.ram_addr_width (ram_addr_width)
	) regs0 (
		.clk          (clk),
		.reset        (reset),
		.address      (address),
		.write        (write),
		.writedata    (writedata),
		.logical_core (logical_core),
		.head_ptr     (head_ptr),
		.incr_ack     (incr_ack),
		.verify_req   (verify_req),
		.verify_task  (verify_task),
		.tail_ptr     (tail_ptr),
		.waitrequest  (waitrequest),
		.phys_core    (phys_core),
		.map_write    (map_write),
		.map_value    (map_value),
		.incr_req     (incr_req),
		.incr_core    (incr_core),
		.verify_ack   (verify_ack),
		.checkin_both (checkin_both),
		.fprint0      (fprint0),
		.fprint1      (fprint1),
		.task0        (task0),
		.task1        (task1)
	);

	fprint_pointers #(
		.ram_addr_width (ram_addr_width)
	) ptrs0 (
		.clk          (clk),
		.reset        (reset),
		.incr_req     (incr_req),
		.incr_core    (incr_core),
		.tail_advance (tail_advance),
		.incr_ack     (incr_ack),
		.head_ptr     (head_ptr),
		.head0        (head0),
		.head1        (head1),
		.tail_ptr     (tail_ptr)
	);

	fprint_comparator #(
		.ram_addr_width (ram_addr_width)
	) comp0 (
		.clk           (clk),
		.reset         (reset),
		.head0         (head0),
		.head1         (head1),
		.tail_ptr      (tail_ptr),
		.fprint0       (fprint0),
		.fprint1       (fprint1),
		.task0         (task0),
		.task1         (task1),
		.checkin_both  (checkin_both),
		.verify_ack    (verify_ack),
		.tail_advance  (tail_advance),
		.mismatch      (mismatch),
		.mismatch_task (mismatch_task),
		.verify_req    (verify_req),
		.verify_task   (verify_task),
		.verified      (verified),
		.verified_task (verified_task)
	);

endmodule

/* sim/fprint_unit_checker.sv */
`timescale 1ns/100ps

module fprint_unit_checker (
	input  logic clk,
	input  logic reset,
	input  logic waitrequest,
	input  logic incr_req,
	input  logic incr_ack,
	input  logic verify_req,
	input  logic verify_ack
);

	// count of failed assertions
	int fail_count = 0;

	// one low cycle per accepted write
	assert property (@(posedge clk) disable iff (reset) !waitrequest |=> waitrequest)
		else begin
			$error("waitrequest stayed low for two cycles in a row");
			fail_count++;
		end

	// increment request held until the pointer block answers
	assert property (@(posedge clk) disable iff (reset) incr_req && !incr_ack |=> incr_req)
		else begin
			$error("incr_req dropped before incr_ack");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (reset) $rose(verify_ack) |-> verify_req)
		else begin
			$error("verify_ack rose with no verify_req");
			fail_count++;
		end

endmodule

/* sim/fprint_unit_tb.sv */
`timescale 1ns/100ps

module fprint_unit_tb;
	import fprint_pkg::*;

	localparam int max_ops = 128;
	localparam int cycles_per_line = 40;
	localparam int event_window = 40;
	localparam int drain_cycles = 30;

	logic                  clk;
	logic                  reset;
	logic [addr_width-1:0] address;
	logic                  write;
	logic [data_width-1:0] writedata;
	logic                  waitrequest;
	logic                  mismatch;
	logic [task_width-1:0] mismatch_task;
	logic                  verified;
	logic [task_width-1:0] verified_task;

	// operations parsed from the test file
	logic [7:0]            op_kind [max_ops];
	logic [8*24-1:0]       op_name [max_ops];
	logic [addr_width-1:0] op_addr [max_ops];
	logic [data_width-1:0] op_data [max_ops];
	int                    op_slot [max_ops];
	int                    op_count;

	logic [half_width-1:0] rand_half [16];
	integer                seed;

	// pulses seen on the outputs, oldest first
	logic [7:0]            ev_kind [$];
	logic [task_width-1:0] ev_task [$];

	int cycles;
	int cycle_limit;

	fprint_unit dut0 (
		.clk           (clk),
		.reset         (reset),
		.address       (address),
		.write         (write),
		.writedata     (writedata),
		.waitrequest   (waitrequest),
		.mismatch      (mismatch),
		.mismatch_task (mismatch_task),
		.verified      (verified),
		.verified_task (verified_task)
	);

	bind fprint_registers fprint_unit_checker chk0 (
		.clk         (clk),
		.reset       (reset),
		.waitrequest (waitrequest),
		.incr_req    (incr_req),
		.incr_ack    (incr_ack),
		.verify_req  (verify_req),
		.verify_ack  (verify_ack)
	);

	always #5 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped at cycle %0d", cycles);
	endtask

	task automatic load_tests();
		integer           fd;
		integer           code;
		integer           s;
		logic [8*8-1:0]   op;
		logic [8*24-1:0]  name;
		logic [8*128-1:0] rest;
		logic [31:0]      a;
		logic [31:0]      d;
		fd = $fopen("sim/fprint_tests.txt", "r");
		if (fd == 0)
			fail_run("cannot open sim/fprint_tests.txt");
		op_count = 0;
		while (!$feof(fd)) begin
			op = '0;
			code = $fscanf(fd, "%s", op);
			if (code == 1) begin
				if (op == "#") begin
					code = $fgets(rest, fd);
				end else begin
					name = '0;
					a = '0;
					d = '0;
					s = 0;
					code = $fscanf(fd, "%s", name);
					if (op == "W")
						code = $fscanf(fd, "%h %h %d", a, d, s);
					else
						code = $fscanf(fd, "%h", d);
					op_kind[op_count] = op[7:0];
					op_name[op_count] = name;
					op_addr[op_count] = a[addr_width-1:0];
					op_data[op_count] = d;
					op_slot[op_count] = s;
					op_count++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic bus_write(input logic [addr_width-1:0] addr,
			input logic [data_width-1:0] data);
		@(posedge clk);
		address   <= addr;
		writedata <= data;
		write     <= 1'b1;
		// held until the slave drops waitrequest
		do
			@(negedge clk);
		while (waitrequest);
		@(posedge clk);
		write <= 1'b0;
	endtask

	task automatic expect_event(input logic [7:0] kind, input logic [task_width-1:0] task_id,
			input logic [8*24-1:0] name);
		int                    waited;
		logic [7:0]            got_kind;
		logic [task_width-1:0] got_task;
		waited = 0;
		while (ev_kind.size() == 0 && waited < event_window) begin
			@(posedge clk);
			waited++;
		end
		assert (ev_kind.size() != 0)
			else fail_run($sformatf("no %s pulse for test %0s within %0d cycles",
				kind, name, event_window));
		got_kind = ev_kind.pop_front();
		got_task = ev_task.pop_front();
		assert (got_kind == kind && got_task == task_id)
			else fail_run($sformatf("MISMATCH test=%0s expected=%s task %0d actual=%s task %0d",
				name, kind, task_id, got_kind, got_task));
	endtask

	// output pulses and bound assertion failures collected on the falling edge
	always @(negedge clk) begin
		assert (dut0.regs0.chk0.fail_count == 0)
			else fail_run("a bound assertion on the bus or the handshakes failed");
		if (!reset && mismatch) begin
			ev_kind.push_back("M");
			ev_task.push_back(mismatch_task);
		end
		if (!reset && verified) begin
			ev_kind.push_back("V");
			ev_task.push_back(verified_task);
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit != 0 && cycles > cycle_limit)
			fail_run($sformatf("timeout after %0d cycles", cycles));
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		address = '0;
		write = 1'b0;
		writedata = '0;
		cycles = 0;
		cycle_limit = 0;
		seed = 32'hd4be;
		for (int k = 0; k < 16; k++)
			rand_half[k] = 16'($random(seed));
		load_tests();
		cycle_limit = cycles_per_line * (op_count + 1);

		repeat (3) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < op_count; i++) begin
			case (op_kind[i])
				"W": begin
					if (op_slot[i] != 0)
						bus_write(op_addr[i], {rand_half[op_slot[i]], op_data[i][15:0]});
					else
						bus_write(op_addr[i], op_data[i]);
				end
				"M", "V": expect_event(op_kind[i], op_data[i][task_width-1:0], op_name[i]);
				default: fail_run($sformatf("unknown operation for test %0s", op_name[i]));
			endcase
		end

		// late pulses still count as unexpected
		repeat (drain_cycles) @(posedge clk);
		if (ev_kind.size() != 0) begin
			fail_run($sformatf("MISMATCH test=end_of_tests expected=none actual=%s task %0d",
				ev_kind[0], ev_task[0]));
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

/* build.f */
hdl/fprint_pkg.sv
hdl/core_map_csr.sv
hdl/fprint_registers.sv
hdl/fprint_pointers.sv
hdl/fprint_comparator.sv
hdl/fprint_unit.sv
sim/fprint_unit_checker.sv
sim/fprint_unit_tb.sv

/* Bender.yml */
package:
  name: fprint_unit

sources:
  - target: any(rtl, simulation)
    files:
      - hdl/fprint_pkg.sv
      - hdl/core_map_csr.sv
      - hdl/fprint_registers.sv
      - hdl/fprint_pointers.sv
      - hdl/fprint_comparator.sv
      - hdl/fprint_unit.sv

  - target: simulation
    files:
      - sim/fprint_unit_checker.sv
      - sim/fprint_unit_tb.sv

/* sim/fprint_tests.txt */
# columns are op and name, then for W the address, data and slot, for M or V the task
# all hex except slot, slot n above 0 takes data bits 31:16 from random half n
W map_core3 32 00000000 0
W map_core9 92 00000001 0
W t1_checkout_a 30 00000012 0
W t1_checkout_b 90 00000012 0
W t1_crc_lo_a 31 a5a50002 0
W t1_crc_hi_a 31 5a5a0022 0
W t1_crc_lo_b 91 a5a50002 0
W t1_crc_hi_b 91 5a5a0022 0
W t1_checkin_a 30 00000002 0
W t1_checkin_b 90 00000002 0
V t1_verify 2
W t2_checkout_a 30 00000015 0
W t2_checkout_b 90 00000015 0
W t2_crc0_lo_a 31 00000005 1
W t2_crc0_hi_a 31 00000025 2
W t2_crc1_lo_a 31 00000005 3
W t2_crc1_hi_a 31 00000025 4
W t2_crc0_lo_b 91 00000005 1
W t2_crc0_hi_b 91 00000025 2
W t2_crc1_lo_b 91 00000005 3
W t2_crc1_hi_b 91 00000025 4
W t2_checkin_a 30 00000005 0
W t2_checkin_b 90 00000005 0
V t2_verify 5
W t3_checkout_a 30 00000017 0
W t3_checkout_b 90 00000017 0
W t3_crc_lo_a 31 12340007 0
W t3_crc_hi_a 31 abcd0027 0
W t3_crc_lo_b 91 12340007 0
W t3_crc_hi_b 91 abce0027 0
M t3_mismatch 7
W t4_stray_hi_a 31 88880024 0
W t4_checkout_a 30 00000014 0
W t4_checkout_b 90 00000014 0
W t4_crc_lo_a 31 0f0f0004 0
W t4_crc_hi_a 31 f0f00024 0
W t4_crc_lo_b 91 0f0f0004 0
W t4_crc_hi_b 91 f0f00024 0
W t4_checkin_a 30 00000004 0
W t4_checkin_b 90 00000004 0
V t4_verify 4
W t5_checkin_a 30 00000006 0
W t5_checkin_b 90 00000006 0
W t6_checkin_a 30 00000002 0
W t6_checkin_b 90 00000002 0
W t6_checkout_a 30 00000012 0
W t6_checkout_b 90 00000012 0
W t6_checkin_a2 30 00000002 0
W t6_checkin_b2 90 00000002 0
V t6_verify 2
